/* include/eeprom_params.svh */
`ifndef EEPROM_PARAMS_SVH
`define EEPROM_PARAMS_SVH

// byte address and data of a 2 Kbyte part
`define EE_ADDR_W   11
`define EE_DATA_W   8

`define EE_DEV_CODE 4'b1010     // serial EEPROM type code

`define CMD_DEPTH   4           // power of two
`define SCL_HALF    2           // CLK cycles per SCL half period

`endif

/* project.f */
+incdir+include
rtl/eeprom_pkg.sv
rtl/eeprom_ifs.sv
rtl/eeprom_cmd_fifo.sv
rtl/eeprom_seq.sv
rtl/i2c_bit_engine.sv
rtl/eeprom_ctrl_top.sv
test/eeprom_model.sv
test/tb_eeprom.sv

/* rtl/eeprom_cmd_fifo.sv */
`default_nettype none

`include "eeprom_params.svh"

module eeprom_cmd_fifo (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    output logic                  busy,
    cmd_if.queue                  cmd
);
    localparam int PTR_W = $clog2(`CMD_DEPTH);

    logic                  rw_mem   [`CMD_DEPTH];
    logic [`EE_ADDR_W-1:0] addr_mem [`CMD_DEPTH];
    logic [`EE_DATA_W-1:0] data_mem [`CMD_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [PTR_W:0]        count;
    logic [PTR_W:0]        count_nxt;
    logic                  push;

    assign push      = (wr | rd) & ~busy;    // strobes while full are lost
    assign count_nxt = count + (PTR_W+1)'(push) - (PTR_W+1)'(cmd.pop);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            busy   <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (cmd.pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_nxt;
            busy  <= (count_nxt == (PTR_W+1)'(`CMD_DEPTH));
        end
    end

    always_ff @(posedge CLK)
    begin
        if (push)
        begin
            rw_mem[wr_ptr]   <= rd & ~wr;    // write wins
            addr_mem[wr_ptr] <= addr;
            data_mem[wr_ptr] <= wdata;
        end
    end

    assign cmd.not_empty = (count != '0);
    assign cmd.rw        = rw_mem[rd_ptr];
    assign cmd.addr      = addr_mem[rd_ptr];
    assign cmd.wdata     = data_mem[rd_ptr];

    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RESET)
        cmd.pop |-> cmd.not_empty);

endmodule

`default_nettype wire

/* rtl/eeprom_ctrl_top.sv */
`default_nettype none

`include "eeprom_params.svh"

module eeprom_ctrl_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    output logic                  busy,
    output logic                  ack,
    output logic [`EE_DATA_W-1:0] rd_data,
    output logic                  scl,
    output logic                  sda_low,    // open-drain pull
    input  logic                  sda_in
);
    cmd_if  u_cmd ();
    byte_if u_bop ();

    eeprom_cmd_fifo u_fifo (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .cmd   (u_cmd)
    );

    eeprom_seq u_seq (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (u_cmd),
        .bop     (u_bop),
        .ack     (ack),
        .rd_data (rd_data)
    );

    i2c_bit_engine u_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .bop     (u_bop),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

`default_nettype wire

/* rtl/eeprom_ifs.sv */
`default_nettype none

`include "eeprom_params.svh"

// head of the command queue
interface cmd_if;
    logic                  not_empty;
    logic                  pop;
    logic                  rw;        // 1 = read
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;

    modport queue (output not_empty, rw, addr, wdata, input pop);
    modport seq   (input not_empty, rw, addr, wdata, output pop);
endinterface

// one bus operation per go
interface byte_if
    import eeprom_pkg::*;
();
    byte_op_e              op;
    ser_byte_u             tx;
    logic                  go;
    logic                  done;
    logic [`EE_DATA_W-1:0] rx;

    modport seq    (output op, tx, go, input done, rx);
    modport engine (input op, tx, go, output done, rx);
endinterface

`default_nettype wire

/* rtl/eeprom_pkg.sv */
`default_nettype none

`include "eeprom_params.svh"

package eeprom_pkg;

    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,
        OP_READ  = 2'd3
    } byte_op_e;

    // one byte on the wire, control byte view or plain
    typedef union packed {
        struct packed {
            logic [3:0]                       dev;
            logic [`EE_ADDR_W-`EE_DATA_W-1:0] page;    // addr[10:8]
            logic                             rw;      // 1 = read
        } ctrl;
        logic [`EE_DATA_W-1:0] raw;
    } ser_byte_u;

endpackage

`default_nettype wire

/* rtl/eeprom_seq.sv */
`default_nettype none

`include "eeprom_params.svh"

module eeprom_seq
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    cmd_if.seq                    cmd,
    byte_if.seq                   bop,
    output logic                  ack,
    output logic [`EE_DATA_W-1:0] rd_data
);
    localparam logic [3:0] S_IDLE    = 4'd0;
    localparam logic [3:0] S_START   = 4'd1;
    localparam logic [3:0] S_CTRL_WR = 4'd2;
    localparam logic [3:0] S_ADDR    = 4'd3;
    localparam logic [3:0] S_DATA_WR = 4'd4;
    localparam logic [3:0] S_RESTART = 4'd5;
    localparam logic [3:0] S_CTRL_RD = 4'd6;
    localparam logic [3:0] S_DATA_RD = 4'd7;
    localparam logic [3:0] S_STOP    = 4'd8;
    localparam logic [3:0] S_DONE    = 4'd9;

    logic [3:0]            state;
    logic                  pending;    // go sent, waiting for done
    logic                  in_op;
    logic                  cmd_rw;
    logic [`EE_ADDR_W-1:0] cmd_addr;
    logic [`EE_DATA_W-1:0] cmd_wdata;
    logic [`EE_DATA_W-1:0] rx_q;

    assign cmd.pop = (state == S_IDLE) && cmd.not_empty;
    assign in_op   = (state != S_IDLE) && (state != S_DONE);
    assign bop.go  = in_op && !pending;

    always_comb
    begin
        bop.op     = OP_WRITE;
        bop.tx.raw = '0;
        case (state)
            S_START, S_RESTART:
                bop.op = OP_START;
            S_CTRL_WR, S_CTRL_RD:
            begin
                bop.tx.ctrl.dev  = `EE_DEV_CODE;
                bop.tx.ctrl.page = cmd_addr[`EE_ADDR_W-1:`EE_DATA_W];
                bop.tx.ctrl.rw   = (state == S_CTRL_RD);
            end
            S_ADDR:
                bop.tx.raw = cmd_addr[`EE_DATA_W-1:0];
            S_DATA_WR:
                bop.tx.raw = cmd_wdata;
            S_DATA_RD:
                bop.op = OP_READ;
            S_STOP:
                bop.op = OP_STOP;
            default:
                bop.op = OP_WRITE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            pending <= 1'b0;
            ack     <= 1'b0;
            rd_data <= '0;
        end
        else
        begin
            ack <= 1'b0;
            if (bop.go)
                pending <= 1'b1;
            else if (bop.done)
                pending <= 1'b0;

            case (state)
                S_IDLE:
                    if (cmd.not_empty)
                        state <= S_START;
                S_START:
                    if (bop.done)
                        state <= S_CTRL_WR;
                S_CTRL_WR:
                    if (bop.done)
                        state <= S_ADDR;
                S_ADDR:
                    if (bop.done)
                        state <= cmd_rw ? S_RESTART : S_DATA_WR;
                S_DATA_WR:
                    if (bop.done)
                        state <= S_STOP;
                S_RESTART:
                    if (bop.done)
                        state <= S_CTRL_RD;
                S_CTRL_RD:
                    if (bop.done)
                        state <= S_DATA_RD;
                S_DATA_RD:
                    if (bop.done)
                        state <= S_STOP;
                S_STOP:
                    if (bop.done)
                    begin
                        ack <= 1'b1;
                        if (cmd_rw)
                            rd_data <= rx_q;
                        state <= S_DONE;
                    end
                S_DONE:
                    state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // command held for the whole frame
    always_ff @(posedge CLK)
    begin
        if (cmd.pop)
        begin
            cmd_rw    <= cmd.rw;
            cmd_addr  <= cmd.addr;
            cmd_wdata <= cmd.wdata;
        end
        if ((state == S_DATA_RD) && bop.done)
            rx_q <= bop.rx;
    end

    // done only ever answers an outstanding go
    a_go_done_pair: assert property (@(posedge CLK) disable iff (RESET)
        bop.done |-> pending);

endmodule

`default_nettype wire

/* rtl/i2c_bit_engine.sv */
`default_nettype none

`include "eeprom_params.svh"

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic   CLK,
    input  logic   RESET,
    byte_if.engine bop,
    output logic   scl,
    output logic   sda_low,
    input  logic   sda_in
);
    localparam int              HC_W     = (`SCL_HALF > 1) ? $clog2(`SCL_HALF) : 1;
    localparam logic [HC_W-1:0] HC_LAST  = HC_W'(`SCL_HALF - 1);
    localparam logic [3:0]      ACK_SLOT = 4'd8;

    logic                  active;
    byte_op_e              op_q;
    logic                  high_ph;    // SCL high half of the slot
    logic [HC_W-1:0]       hcnt;
    logic [3:0]            bcnt;       // slot within the operation
    logic [`EE_DATA_W-1:0] sh;
    logic                  is_cond;
    logic                  last_slot;

    assign is_cond   = (op_q == OP_START) || (op_q == OP_STOP);
    assign last_slot = is_cond ? (bcnt == 4'd0) : (bcnt == ACK_SLOT);
    assign bop.rx    = sh;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            op_q     <= OP_START;
            high_ph  <= 1'b0;
            hcnt     <= '0;
            bcnt     <= '0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
            bop.done <= 1'b0;
        end
        else
        begin
            bop.done <= 1'b0;
            if (!active)
            begin
                if (bop.go)
                begin
                    active  <= 1'b1;
                    op_q    <= bop.op;
                    high_ph <= 1'b0;
                    hcnt    <= '0;
                    bcnt    <= '0;
                    scl     <= 1'b0;
                end
            end
            else if (!high_ph)
            begin
                if (hcnt == '0)    // SCL already low here
                begin
                    case (op_q)
                        OP_STOP:  sda_low <= 1'b1;
                        OP_WRITE: sda_low <= (bcnt != ACK_SLOT) && !sh[`EE_DATA_W-1];
                        default:  sda_low <= 1'b0;    // released
                    endcase
                end
                if (hcnt == HC_LAST)
                begin
                    hcnt    <= '0;
                    high_ph <= 1'b1;
                    scl     <= 1'b1;
                end
                else
                    hcnt <= hcnt + 1'b1;
            end
            else
            begin
                if (hcnt == '0)
                begin
                    if (op_q == OP_START)
                        sda_low <= 1'b1;    // falling SDA under high SCL
                    else if (op_q == OP_STOP)
                        sda_low <= 1'b0;
                end
                if (hcnt == HC_LAST)
                begin
                    hcnt <= '0;
                    if (last_slot)
                    begin
                        active   <= 1'b0;
                        bop.done <= 1'b1;    // scl stays parked high
                    end
                    else
                    begin
                        bcnt    <= bcnt + 1'b1;
                        high_ph <= 1'b0;
                        scl     <= 1'b0;
                    end
                end
                else
                    hcnt <= hcnt + 1'b1;
            end
        end
    end

    // msb first out, bus sampled just after SCL rises
    always_ff @(posedge CLK)
    begin
        if (!active && bop.go)
            sh <= bop.tx.raw;
        else if (active && high_ph && (hcnt == '0) && (bcnt != ACK_SLOT))
            sh <= {sh[`EE_DATA_W-2:0], sda_in};
    end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(active && is_cond)) |-> $stable(sda_low));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the EEPROM controller testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f project.f --top-module tb_eeprom -o tb_eeprom --Mdir obj_dir > build.log 2>&1 ||
    { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_eeprom > sim.log 2>&1 ; cat sim.log
grep -q "Verification passed" sim.log && echo "PASS" ||
    { echo "FAIL"; exit 1; }

/* test/eeprom_model.sv */
`default_nettype none

`include "eeprom_params.svh"

// serial EEPROM slave, sampled on CLK so it never races the DUT
module eeprom_model
    import eeprom_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  scl,
    input  logic                  sda,
    output logic                  sda_low,
    output logic                  ctrl_stb,    // control byte received
    output ser_byte_u             ctrl_byte,
    output logic                  ctrl_rs,     // it followed a repeated start
    output logic                  wr_stb,      // memory written
    output logic [`EE_ADDR_W-1:0] wr_addr,
    output logic [`EE_DATA_W-1:0] wr_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`EE_DATA_W-1:0] mem [2**`EE_ADDR_W];
    logic                  scl_q;
    logic                  sda_q;
    logic                  in_frame;
    logic                  restarted;
    logic                  rd_mode;
    logic                  sending;
    logic [3:0]            cnt;        // SCL rises within the byte
    logic [1:0]            byte_num;
    ser_byte_u             sh;
    logic [`EE_ADDR_W-1:0] ptr;
    logic [`EE_DATA_W-1:0] tx;

    initial
    begin
        for (int i = 0; i < 2**`EE_ADDR_W; i++)
            mem[i] = 8'hFF;    // erased part
    end

    always @(posedge CLK)
    begin
        scl_q    <= scl;
        sda_q    <= sda;
        ctrl_stb <= 1'b0;
        wr_stb   <= 1'b0;
        if (RESET)
        begin
            in_frame  <= 1'b0;
            restarted <= 1'b0;
            rd_mode   <= 1'b0;
            sending   <= 1'b0;
            sda_low   <= 1'b0;
            cnt       <= '0;
            byte_num  <= '0;
        end
        else if (scl && scl_q && sda_q && !sda)    // start or repeated start
        begin
            restarted <= in_frame;
            in_frame  <= 1'b1;
            sending   <= 1'b0;
            sda_low   <= 1'b0;
            cnt       <= '0;
            byte_num  <= '0;
        end
        else if (scl && scl_q && !sda_q && sda)    // stop
        begin
            in_frame <= 1'b0;
            rd_mode  <= 1'b0;
            sending  <= 1'b0;
            sda_low  <= 1'b0;
        end
        else if (in_frame && scl && !scl_q)
        begin
            if (cnt < 4'd8)
                sh.raw <= {sh.raw[`EE_DATA_W-2:0], sda};
            cnt <= cnt + 1'b1;
        end
        else if (in_frame && !scl && scl_q)
        begin
            if (cnt == 4'd8)
            begin
                if (sending)
                    sda_low <= 1'b0;    // master's ack slot
                else
                begin
                    sda_low <= 1'b1;
                    case (byte_num)
                        2'd0:
                        begin
                            ctrl_stb  <= 1'b1;
                            ctrl_byte <= sh;
                            ctrl_rs   <= restarted;
                            rd_mode   <= sh.ctrl.rw;
                            ptr[`EE_ADDR_W-1:`EE_DATA_W] <= sh.ctrl.page;
                        end
                        2'd1:
                            ptr[`EE_DATA_W-1:0] <= sh.raw;
                        2'd2:
                            if (!rd_mode)
                            begin
                                mem[ptr] <= sh.raw;
                                wr_stb   <= 1'b1;
                                wr_addr  <= ptr;
                                wr_data  <= sh.raw;
                            end
                        default: ;
                    endcase
                end
            end
            else if (cnt == 4'd9)
            begin
                cnt      <= '0;
                byte_num <= byte_num + 1'b1;
                if (rd_mode && !sending)
                begin
                    sending <= 1'b1;
                    sda_low <= !mem[ptr][`EE_DATA_W-1];
                    tx      <= mem[ptr] << 1;
                end
                else
                begin
                    sending <= 1'b0;
                    sda_low <= 1'b0;
                end
            end
            else if (sending)
            begin
                sda_low <= !tx[`EE_DATA_W-1];
                tx      <= tx << 1;
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_eeprom.sv */
`default_nettype none

`include "eeprom_params.svh"

module tb_eeprom
    import eeprom_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_CMDS      = 64;
    localparam int CYCLE_LIMIT = N_CMDS * 40 * 2 * `SCL_HALF + 4000;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic                  busy;
    logic                  ack;
    logic [`EE_DATA_W-1:0] rd_data;
    logic                  scl;
    logic                  sda_low_dut;
    logic                  sda_low_mem;
    logic                  sda_bus;
    logic                  ctrl_stb;
    ser_byte_u             ctrl_byte;
    logic                  ctrl_rs;
    logic                  wr_stb;
    logic [`EE_ADDR_W-1:0] wr_addr;
    logic [`EE_DATA_W-1:0] wr_data;

    // scoreboard
    logic [`EE_DATA_W-1:0] exp_mem [2**`EE_ADDR_W];
    logic [`EE_DATA_W-1:0] exp_reads [$];
    logic                  q_rw [$];
    logic [`EE_ADDR_W-1:0] q_addr [$];
    logic [`EE_DATA_W-1:0] q_wdata [$];
    logic                  head_valid;
    logic                  head_rw;
    logic [`EE_ADDR_W-1:0] head_addr;
    logic [`EE_DATA_W-1:0] head_wdata;
    logic [`EE_DATA_W-1:0] head_exp;
    int                    outstanding;
    logic                  seen_strobe;
    int                    n_accepted;
    int                    n_acks;
    int                    errors;
    int                    cycles;
    integer                seed;
    logic [31:0]           r;

    assign sda_bus = !(sda_low_dut || sda_low_mem);    // pull-up

    eeprom_ctrl_top u_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wdata   (wdata),
        .busy    (busy),
        .ack     (ack),
        .rd_data (rd_data),
        .scl     (scl),
        .sda_low (sda_low_dut),
        .sda_in  (sda_bus)
    );

    eeprom_model u_mem (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda_bus),
        .sda_low   (sda_low_mem),
        .ctrl_stb  (ctrl_stb),
        .ctrl_byte (ctrl_byte),
        .ctrl_rs   (ctrl_rs),
        .wr_stb    (wr_stb),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    always #5 CLK = ~CLK;

    // oldest unacked command is the one on the bus
    always @(posedge CLK)
    begin
        if (RESET)
        begin
            seen_strobe <= 1'b0;
            head_valid  <= 1'b0;
            outstanding <= 0;
        end
        else
        begin
            if (ack)
            begin
                n_acks++;
                if (q_rw.size() > 0)
                begin
                    if (q_rw[0])
                        void'(exp_reads.pop_front());
                    void'(q_rw.pop_front());
                    void'(q_addr.pop_front());
                    void'(q_wdata.pop_front());
                end
            end
            if ((wr || rd) && !busy)
            begin
                n_accepted++;
                seen_strobe <= 1'b1;
                q_rw.push_back(rd && !wr);    // write wins
                q_addr.push_back(addr);
                q_wdata.push_back(wdata);
                if (rd && !wr)
                    exp_reads.push_back(exp_mem[addr]);
                else
                    exp_mem[addr] = wdata;
            end
            outstanding <= q_rw.size();
            head_valid  <= (q_rw.size() > 0);
            head_rw     <= (q_rw.size() > 0) ? q_rw[0] : 1'b0;
            head_addr   <= (q_rw.size() > 0) ? q_addr[0] : '0;
            head_wdata  <= (q_rw.size() > 0) ? q_wdata[0] : '0;
            head_exp    <= (exp_reads.size() > 0) ? exp_reads[0] : '0;
        end
    end

    a_reset_idle: assert property (@(posedge CLK) disable iff (RESET)
        !seen_strobe |-> (!ack && !busy && !sda_low_dut && scl))
    else
    begin
        errors++;
        $display("ERROR t=%0t ack/busy/sda_low/scl got %b/%b/%b/%b expected 0/0/0/1",
                 $time, $sampled(ack), $sampled(busy), $sampled(sda_low_dut),
                 $sampled(scl));
    end

    a_rd_data: assert property (@(posedge CLK) disable iff (RESET)
        (ack && head_rw) |-> (rd_data == head_exp))
    else
    begin
        errors++;
        $display("ERROR t=%0t rd_data got %h expected %h",
                 $time, $sampled(rd_data), $sampled(head_exp));
    end

    a_ack_owed: assert property (@(posedge CLK) disable iff (RESET) ack |-> head_valid)
    else
    begin
        errors++;
        $display("ack pulse at %0t with no accepted command outstanding", $time);
    end

    a_dev_code: assert property (@(posedge CLK) disable iff (RESET)
        ctrl_stb |-> (ctrl_byte.ctrl.dev == `EE_DEV_CODE))
    else
    begin
        errors++;
        $display("ERROR t=%0t ctrl.dev got %b expected %b",
                 $time, $sampled(ctrl_byte.ctrl.dev), 4'(`EE_DEV_CODE));
    end

    a_page: assert property (@(posedge CLK) disable iff (RESET)
        ctrl_stb |-> (ctrl_byte.ctrl.page == head_addr[`EE_ADDR_W-1:`EE_DATA_W]))
    else
    begin
        errors++;
        $display("ERROR t=%0t ctrl.page got %0d expected %0d", $time,
                 $sampled(ctrl_byte.ctrl.page),
                 $sampled(head_addr[`EE_ADDR_W-1:`EE_DATA_W]));
    end

    a_rw_bit: assert property (@(posedge CLK) disable iff (RESET)
        ctrl_stb |-> (ctrl_byte.ctrl.rw == ctrl_rs))
    else
    begin
        errors++;
        $display("ERROR t=%0t ctrl.rw got %b expected %b",
                 $time, $sampled(ctrl_byte.ctrl.rw), $sampled(ctrl_rs));
    end

    a_mem_write: assert property (@(posedge CLK) disable iff (RESET)
        wr_stb |-> (head_valid && !head_rw && wr_addr == head_addr && wr_data == head_wdata))
    else
    begin
        errors++;
        $display("ERROR t=%0t wr_addr/wr_data got %h/%h expected %h/%h", $time,
                 $sampled(wr_addr), $sampled(wr_data),
                 $sampled(head_addr), $sampled(head_wdata));
    end

    // one in flight plus a full queue
    a_busy_full: assert property (@(posedge CLK) disable iff (RESET)
        (outstanding == `CMD_DEPTH + 1) |-> busy)
    else
    begin
        errors++;
        $display("ERROR t=%0t busy got 0 expected 1", $time);
    end

    a_busy_early: assert property (@(posedge CLK) disable iff (RESET)
        busy |-> (outstanding >= `CMD_DEPTH))
    else
    begin
        errors++;
        $display("ERROR t=%0t busy got 1 expected 0", $time);
    end

    task automatic send_cmd(input logic w, input logic rr,
                            input logic [`EE_ADDR_W-1:0] a,
                            input logic [`EE_DATA_W-1:0] d);
        @(negedge CLK);
        while (busy)
            @(negedge CLK);
        wr    = w;
        rd    = rr;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    // strobes on back-to-back cycles, busy ignored
    task automatic burst_writes(input int n, input logic [`EE_ADDR_W-1:0] base);
        for (int i = 0; i < n; i++)
        begin
            @(negedge CLK);
            wr    = 1'b1;
            rd    = 1'b0;
            addr  = base + `EE_ADDR_W'(i);
            wdata = 8'hA0 + `EE_DATA_W'(i);
        end
        @(negedge CLK);
        wr = 1'b0;
    endtask

    task automatic drain();
        while (outstanding != 0)
            @(negedge CLK);
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d commands still outstanding",
                 cycles, outstanding);
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        for (int i = 0; i < 2**`EE_ADDR_W; i++)
            exp_mem[i] = 8'hFF;
        CLK        = 1'b0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wdata      = '0;
        n_accepted = 0;
        n_acks     = 0;
        errors     = 0;
        seed       = 32'h4a18;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        repeat (5) @(negedge CLK);

        send_cmd(1'b1, 1'b0, 11'h2A5, 8'h3C);
        send_cmd(1'b0, 1'b1, 11'h2A5, 8'h00);
        send_cmd(1'b0, 1'b1, 11'h013, 8'h00);    // never written
        send_cmd(1'b1, 1'b1, 11'h4C1, 8'h5A);    // both strobes
        send_cmd(1'b0, 1'b1, 11'h4C1, 8'h00);
        drain();

        burst_writes(8, 11'h700);
        for (int i = 0; i < 8; i++)
            send_cmd(1'b0, 1'b1, 11'h700 + 11'(i), 8'h00);
        drain();

        for (int i = 0; i < 40; i++)
        begin
            r = $random(seed);
            send_cmd(!r[16], r[16], {r[10:8], 4'h0, r[3:0]}, r[31:24]);
            repeat (r[13:12]) @(negedge CLK);
        end
        drain();
        repeat (10) @(negedge CLK);

        if (n_acks != n_accepted)
        begin
            errors++;
            $display("ERROR t=%0t ack count got %0d expected %0d", $time, n_acks, n_accepted);
        end
        $display("accepted=%0d acks=%0d errors=%0d", n_accepted, n_acks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
